// ==== hw/spawn_queue_pkg.sv ====
// Spawn queue geometry and the bit layout of a queue entry.
`default_nettype none

package spawn_queue_pkg;

    localparam int QUEUE_LEN = 128;
    localparam int QUEUE_BITS = $clog2(QUEUE_LEN);

    // header word.
    localparam int ENTRY_VALID_BYTE_OFFSET = 56;
    localparam int ENTRY_VALID_OFFSET = 63;
    localparam int NUM_ARGS_OFFSET = 0;
    localparam int NUM_DEPS_OFFSET = 8;
    localparam int NUM_COPS_OFFSET = 16;

    // third body word.
    localparam int TASKTYPE_L = 0;
    localparam int TASKTYPE_H = 31;
    localparam int ARCH_L = 32;
    localparam int ARCH_H = 33;

    localparam int ENTRY_FIXED_SLOTS = 4;
    localparam int COP_SLOTS = 3;

    // slots taken by one entry, at most 79.
    function automatic logic [QUEUE_BITS-1:0] entry_slots(input logic [3:0] args,
                                                          input logic [3:0] deps,
                                                          input logic [3:0] cops);
        return QUEUE_BITS'(ENTRY_FIXED_SLOTS) + QUEUE_BITS'(args) + QUEUE_BITS'(deps)
            + QUEUE_BITS'(COP_SLOTS) * QUEUE_BITS'(cops);
    endfunction

endpackage

`default_nettype wire

// ==== hw/spawn_cmd_pkg.sv ====
// New-task command descriptor layout and queue writer return codes.
`default_nettype none

package spawn_cmd_pkg;

    localparam int TASKTYPE_BITS = 32;
    localparam int ARCH_BITS = 2;

    // descriptor word.
    localparam int DESC_TYPE_L = 0;
    localparam int DESC_TYPE_H = 31;
    localparam int DESC_ARCH_L = 32;
    localparam int DESC_ARCH_H = 33;
    localparam int DESC_ARGS_L = 40;
    localparam int DESC_DEPS_L = 44;
    localparam int DESC_COPS_L = 48;

    typedef enum logic [1:0] {
        SPAWN_WAIT   = 2'd0,
        SPAWN_OK     = 2'd1,
        SPAWN_REJECT = 2'd2
    } spawn_ret_t;

endpackage

`default_nettype wire

// ==== hw/spawn_cmd_parser.sv ====
// New-task command parser that collects the fixed words and feeds payload to the writer.
`timescale 1ns/100ps
`default_nettype none

module spawn_cmd_parser (
    input  wire                                    clk,
    input  wire                                    rstn,
    input  wire                                    in_valid,
    input  wire [63:0]                             in_data,
    input  wire                                    in_last,
    output logic                                   in_ready,
    output logic                                   spawn_start,
    output logic [63:0]                            task_id,
    output logic [63:0]                            ptask_id,
    output logic [spawn_cmd_pkg::TASKTYPE_BITS-1:0] task_type,
    output logic [spawn_cmd_pkg::ARCH_BITS-1:0]     task_arch,
    output logic [3:0]                             num_args,
    output logic [3:0]                             num_deps,
    output logic [3:0]                             num_cops,
    output logic [63:0]                            buf_data,
    output logic                                   buf_last,
    output logic                                   buf_valid,
    input  wire                                    buf_ready,
    input  spawn_cmd_pkg::spawn_ret_t              spawn_ret
);

    import spawn_cmd_pkg::*;

    typedef enum logic [1:0] {P_IDLE, P_COLLECT, P_BUSY, P_RETRY} parser_state_t;

    parser_state_t state;
    logic [1:0] word_cnt;
    logic pl_done;
    logic take;

    // payload words only go into an empty buffer.
    assign in_ready = (state == P_COLLECT) ||
                      ((state == P_BUSY || state == P_RETRY) && !buf_valid && !pl_done);
    assign take = in_valid && in_ready;

    always_ff @(posedge clk) begin
        spawn_start <= 1'b0;
        if (buf_ready) begin
            buf_valid <= 1'b0;
        end
        if (take && state != P_COLLECT) begin
            buf_data <= in_data;
            buf_last <= in_last;
            buf_valid <= 1'b1;
            pl_done <= in_last;
        end

        case (state)
            P_IDLE: begin
                word_cnt <= 2'd0;
                state <= P_COLLECT;
            end
            P_COLLECT: begin
                if (take) begin
                    word_cnt <= word_cnt + 2'd1;
                    case (word_cnt)
                        2'd0: begin
                            task_type <= in_data[DESC_TYPE_H:DESC_TYPE_L];
                            task_arch <= in_data[DESC_ARCH_H:DESC_ARCH_L];
                            num_args <= in_data[DESC_ARGS_L +: 4];
                            num_deps <= in_data[DESC_DEPS_L +: 4];
                            num_cops <= in_data[DESC_COPS_L +: 4];
                        end
                        2'd1: task_id <= in_data;
                        default: begin
                            ptask_id <= in_data;
                            word_cnt <= 2'd0;
                            pl_done <= (num_args | num_deps | num_cops) == 4'd0;
                            spawn_start <= 1'b1;
                            state <= P_BUSY;
                        end
                    endcase
                end
            end
            P_BUSY: begin
                if (spawn_ret == SPAWN_OK) begin
                    state <= P_COLLECT;
                end else if (spawn_ret == SPAWN_REJECT) begin
                    state <= P_RETRY;
                end
            end
            default: begin
                // same command again, the writer keeps its reclaim progress.
                spawn_start <= 1'b1;
                state <= P_BUSY;
            end
        endcase

        if (!rstn) begin
            state <= P_IDLE;
            word_cnt <= 2'd0;
            pl_done <= 1'b0;
            spawn_start <= 1'b0;
            buf_valid <= 1'b0;
        end
    end

    // one command in flight at a time.
    assert property (@(posedge clk) disable iff (!rstn)
        spawn_start |=> !spawn_start until_with (spawn_ret != SPAWN_WAIT));

endmodule

`default_nettype wire

// ==== hw/spawn_queue_writer.sv ====
// Spawn queue writer that reserves room, reclaims consumed entries and commits new ones.
`timescale 1ns/100ps
`default_nettype none

module spawn_queue_writer (
    input  wire                                     clk,
    input  wire                                     rstn,
    input  wire                                     spawn_start,
    input  wire [63:0]                              task_id,
    input  wire [63:0]                              ptask_id,
    input  wire [spawn_cmd_pkg::TASKTYPE_BITS-1:0]  task_type,
    input  wire [spawn_cmd_pkg::ARCH_BITS-1:0]      task_arch,
    input  wire [3:0]                               num_args,
    input  wire [3:0]                               num_deps,
    input  wire [3:0]                               num_cops,
    input  wire [63:0]                              buf_data,
    input  wire                                     buf_last,
    input  wire                                     buf_valid,
    output logic                                    buf_ready,
    output logic [spawn_queue_pkg::QUEUE_BITS-1:0]  q_addr,
    output logic                                    q_en,
    output logic [7:0]                              q_we,
    output logic [63:0]                             q_din,
    input  wire [63:0]                              q_dout,
    output spawn_cmd_pkg::spawn_ret_t               spawn_ret
);

    import spawn_queue_pkg::*;
    import spawn_cmd_pkg::*;

    typedef enum logic [3:0] {
        W_IDLE, W_CHECK, W_READ, W_COMPUTE, W_UPDATE,
        W_TASKID, W_PTASKID, W_TYPE, W_REST_1, W_REST_2, W_HEADER
    } writer_state_t;

    writer_state_t state;
    logic [QUEUE_BITS-1:0] wr_idx;
    logic [QUEUE_BITS-1:0] hdr_idx;
    logic [QUEUE_BITS-1:0] rcl_idx;
    logic [QUEUE_BITS:0] avail_slots;
    logic [QUEUE_BITS-1:0] needed_slots;
    logic [QUEUE_BITS-1:0] rcl_len;
    logic [3:0] rcl_args;
    logic [3:0] rcl_deps;
    logic [3:0] rcl_cops;

    assign buf_ready = (state == W_REST_1) && buf_valid;

    always_comb begin
        q_addr = wr_idx;
        q_en = 1'b0;
        q_we = 8'hff;
        q_din = task_id;
        case (state)
            W_CHECK: begin
                // header at the reclaim index is only used when room is short.
                q_addr = rcl_idx;
                q_en = 1'b1;
                q_we = 8'h00;
            end
            W_TASKID: q_en = 1'b1;
            W_PTASKID: begin
                q_en = 1'b1;
                q_din = ptask_id;
            end
            W_TYPE: begin
                q_en = 1'b1;
                q_din = '0;
                q_din[TASKTYPE_H:TASKTYPE_L] = task_type;
                q_din[ARCH_H:ARCH_L] = task_arch;
            end
            W_REST_2: begin
                q_en = 1'b1;
                q_din = buf_data;
            end
            W_HEADER: begin
                q_addr = hdr_idx;
                q_en = 1'b1;
                q_din = '0;
                q_din[ENTRY_VALID_BYTE_OFFSET +: 8] = 8'h80;
                q_din[NUM_ARGS_OFFSET +: 8] = {4'd0, num_args};
                q_din[NUM_DEPS_OFFSET +: 8] = {4'd0, num_deps};
                q_din[NUM_COPS_OFFSET +: 8] = {4'd0, num_cops};
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        spawn_ret <= SPAWN_WAIT;
        case (state)
            W_IDLE: begin
                needed_slots <= entry_slots(num_args, num_deps, num_cops);
                if (spawn_start) begin
                    state <= W_CHECK;
                end
            end
            W_CHECK: begin
                if ({1'b0, needed_slots} <= avail_slots) begin
                    hdr_idx <= wr_idx;
                    wr_idx <= wr_idx + QUEUE_BITS'(1);
                    state <= W_TASKID;
                end else begin
                    state <= W_READ;
                end
            end
            W_READ: begin
                rcl_args <= q_dout[NUM_ARGS_OFFSET +: 4];
                rcl_deps <= q_dout[NUM_DEPS_OFFSET +: 4];
                rcl_cops <= q_dout[NUM_COPS_OFFSET +: 4];
                if (q_dout[ENTRY_VALID_OFFSET]) begin
                    spawn_ret <= SPAWN_REJECT;
                    state <= W_IDLE;
                end else begin
                    state <= W_COMPUTE;
                end
            end
            W_COMPUTE: begin
                rcl_len <= entry_slots(rcl_args, rcl_deps, rcl_cops);
                state <= W_UPDATE;
            end
            W_UPDATE: begin
                avail_slots <= avail_slots + {1'b0, rcl_len};
                rcl_idx <= rcl_idx + rcl_len;
                state <= W_CHECK;
            end
            W_TASKID, W_PTASKID: begin
                wr_idx <= wr_idx + QUEUE_BITS'(1);
                state <= (state == W_TASKID) ? W_PTASKID : W_TYPE;
            end
            W_TYPE: begin
                wr_idx <= wr_idx + QUEUE_BITS'(1);
                if (needed_slots == QUEUE_BITS'(ENTRY_FIXED_SLOTS)) begin
                    state <= W_HEADER;
                end else begin
                    state <= W_REST_1;
                end
            end
            W_REST_1: begin
                if (buf_valid) begin
                    state <= W_REST_2;
                end
            end
            W_REST_2: begin
                wr_idx <= wr_idx + QUEUE_BITS'(1);
                state <= buf_last ? W_HEADER : W_REST_1;
            end
            default: begin
                // the header goes last and publishes the entry.
                avail_slots <= avail_slots - {1'b0, needed_slots};
                spawn_ret <= SPAWN_OK;
                state <= W_IDLE;
            end
        endcase

        if (!rstn) begin
            state <= W_IDLE;
            spawn_ret <= SPAWN_WAIT;
            avail_slots <= (QUEUE_BITS + 1)'(QUEUE_LEN);
            wr_idx <= '0;
            rcl_idx <= '0;
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        avail_slots <= (QUEUE_BITS + 1)'(QUEUE_LEN));

    // a pop must empty the parser buffer on the next cycle.
    assert property (@(posedge clk) disable iff (!rstn)
        buf_ready |=> !buf_valid);

endmodule

`default_nettype wire

// ==== hw/spawn_queue_ram.sv ====
// Dual-port spawn queue memory with byte-lane writes and registered reads.
`timescale 1ns/100ps
`default_nettype none

module spawn_queue_ram (
    input  wire                                     clk,
    input  wire [spawn_queue_pkg::QUEUE_BITS-1:0]   a_addr,
    input  wire                                     a_en,
    input  wire [7:0]                               a_we,
    input  wire [63:0]                              a_din,
    output logic [63:0]                             a_dout,
    input  wire [spawn_queue_pkg::QUEUE_BITS-1:0]   b_addr,
    input  wire                                     b_en,
    input  wire [7:0]                               b_we,
    input  wire [63:0]                              b_din,
    output logic [63:0]                             b_dout
);

    import spawn_queue_pkg::*;

    logic [63:0] mem [QUEUE_LEN];

    // read-first on both ports.
    always_ff @(posedge clk) begin
        if (a_en) begin
            a_dout <= mem[a_addr];
            for (int i = 0; i < 8; i++) begin
                if (a_we[i]) begin
                    mem[a_addr][8*i +: 8] <= a_din[8*i +: 8];
                end
            end
        end
        if (b_en) begin
            b_dout <= mem[b_addr];
            for (int i = 0; i < 8; i++) begin
                if (b_we[i]) begin
                    mem[b_addr][8*i +: 8] <= b_din[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/spawn_queue_drain.sv ====
// Spawn queue drain that streams committed entries out in order and frees them.
`timescale 1ns/100ps
`default_nettype none

module spawn_queue_drain (
    input  wire                                     clk,
    input  wire                                     rstn,
    output logic [spawn_queue_pkg::QUEUE_BITS-1:0]  q_addr,
    output logic                                    q_en,
    output logic [7:0]                              q_we,
    output logic [63:0]                             q_din,
    input  wire [63:0]                              q_dout,
    output logic                                    out_valid,
    output logic [63:0]                             out_data,
    output logic                                    out_last,
    input  wire                                     out_ready
);

    import spawn_queue_pkg::*;

    typedef enum logic [2:0] {D_IDLE, D_POLL, D_CHECK, D_OUT, D_FETCH, D_CLEAR} drain_state_t;

    drain_state_t state;
    logic [QUEUE_BITS-1:0] rd_idx;
    logic [QUEUE_BITS-1:0] cnt;
    logic [QUEUE_BITS-1:0] ent_len;

    always_comb begin
        q_addr = rd_idx + cnt;
        q_en = 1'b0;
        q_we = 8'h00;
        q_din = '0;
        case (state)
            D_POLL: begin
                q_addr = rd_idx;
                q_en = 1'b1;
            end
            D_OUT: q_en = out_ready && !out_last;
            D_CLEAR: begin
                q_addr = rd_idx;
                q_en = 1'b1;
                q_we = 8'h01 << (ENTRY_VALID_BYTE_OFFSET / 8);
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        case (state)
            D_IDLE: state <= D_POLL;
            D_POLL: state <= D_CHECK;
            D_CHECK: begin
                if (q_dout[ENTRY_VALID_OFFSET]) begin
                    ent_len <= entry_slots(q_dout[NUM_ARGS_OFFSET +: 4],
                                           q_dout[NUM_DEPS_OFFSET +: 4],
                                           q_dout[NUM_COPS_OFFSET +: 4]);
                    out_data <= q_dout;
                    out_valid <= 1'b1;
                    out_last <= 1'b0;
                    cnt <= QUEUE_BITS'(1);
                    state <= D_OUT;
                end else begin
                    state <= D_POLL;
                end
            end
            D_OUT: begin
                if (out_ready) begin
                    out_valid <= 1'b0;
                    if (out_last) begin
                        state <= D_CLEAR;
                    end else begin
                        state <= D_FETCH;
                    end
                end
            end
            D_FETCH: begin
                out_data <= q_dout;
                out_valid <= 1'b1;
                out_last <= (cnt == ent_len - QUEUE_BITS'(1));
                cnt <= cnt + QUEUE_BITS'(1);
                state <= D_OUT;
            end
            default: begin
                // clearing the header valid byte frees the whole entry.
                rd_idx <= rd_idx + ent_len;
                state <= D_POLL;
            end
        endcase

        if (!rstn) begin
            state <= D_IDLE;
            rd_idx <= '0;
            cnt <= '0;
            out_valid <= 1'b0;
            out_last <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last));

endmodule

`default_nettype wire

// ==== hw/spawn_out_top.sv ====
// Spawn-out path top level with parser, queue writer, queue memory and drain.
`timescale 1ns/100ps
`default_nettype none

module spawn_out_top (
    input  wire         clk,
    input  wire         rstn,
    input  wire         in_valid,
    input  wire [63:0]  in_data,
    input  wire         in_last,
    output logic        in_ready,
    output logic        out_valid,
    output logic [63:0] out_data,
    output logic        out_last,
    input  wire         out_ready,
    output logic        spawn_ok,
    output logic        spawn_full
);

    import spawn_queue_pkg::*;
    import spawn_cmd_pkg::*;

    logic spawn_start;
    logic [63:0] task_id;
    logic [63:0] ptask_id;
    logic [TASKTYPE_BITS-1:0] task_type;
    logic [ARCH_BITS-1:0] task_arch;
    logic [3:0] num_args;
    logic [3:0] num_deps;
    logic [3:0] num_cops;
    logic [63:0] buf_data;
    logic buf_last;
    logic buf_valid;
    logic buf_ready;
    spawn_ret_t spawn_ret;

    // ####################
    // queue ports.
    logic [QUEUE_BITS-1:0] a_addr;
    logic a_en;
    logic [7:0] a_we;
    logic [63:0] a_din;
    logic [63:0] a_dout;
    logic [QUEUE_BITS-1:0] b_addr;
    logic b_en;
    logic [7:0] b_we;
    logic [63:0] b_din;
    logic [63:0] b_dout;

    assign spawn_ok = (spawn_ret == SPAWN_OK);
    assign spawn_full = (spawn_ret == SPAWN_REJECT);

    spawn_cmd_parser spawn_cmd_parser_inst (
        .clk, .rstn, .in_valid, .in_data, .in_last, .in_ready, .spawn_start,
        .task_id, .ptask_id, .task_type, .task_arch, .num_args, .num_deps, .num_cops,
        .buf_data, .buf_last, .buf_valid, .buf_ready, .spawn_ret
    );

    spawn_queue_writer spawn_queue_writer_inst (
        .clk, .rstn, .spawn_start, .task_id, .ptask_id, .task_type, .task_arch,
        .num_args, .num_deps, .num_cops, .buf_data, .buf_last, .buf_valid, .buf_ready,
        .q_addr(a_addr), .q_en(a_en), .q_we(a_we), .q_din(a_din), .q_dout(a_dout),
        .spawn_ret
    );

    spawn_queue_ram spawn_queue_ram_inst (
        .clk, .a_addr, .a_en, .a_we, .a_din, .a_dout,
        .b_addr, .b_en, .b_we, .b_din, .b_dout
    );

    spawn_queue_drain spawn_queue_drain_inst (
        .clk, .rstn, .q_addr(b_addr), .q_en(b_en), .q_we(b_we), .q_din(b_din),
        .q_dout(b_dout), .out_valid, .out_data, .out_last, .out_ready
    );

endmodule

`default_nettype wire

// ==== verification/spawn_out_tb.sv ====
// Testbench for the spawn-out path, driving new-task commands and checking the drained entries.
`timescale 1ns/100ps
`default_nettype none

module spawn_out_tb;

    localparam int NUM_ROWS = 15;
    localparam int STALL_LEN = 1024;

    typedef struct packed {
        logic [3:0]  args;
        logic [3:0]  deps;
        logic [3:0]  cops;
        logic [63:0] task_id;
        logic [63:0] ptask_id;
        logic [31:0] task_type;
        logic [1:0]  arch;
        logic [15:0] hold;
        logic        rnd_stall;
    } row_t;

    logic clk;
    logic rstn;
    logic in_valid;
    logic [63:0] in_data;
    logic in_last;
    logic in_ready;
    logic out_valid;
    logic [63:0] out_data;
    logic out_last;
    logic out_ready;
    logic spawn_ok;
    logic spawn_full;

    row_t rows [NUM_ROWS];
    logic [63:0] in_words [$];
    logic in_lasts [$];
    logic [63:0] exp_words [$];
    logic exp_lasts [$];
    logic stall_pat [STALL_LEN];
    int in_idx;
    int cur_entry;
    int word_idx;
    int entry_errs;
    int hold_left;
    int stall_ptr;
    int err_cnt;
    int ok_cnt;
    int full_cnt;
    int cycles;
    int limit;
    logic run_active;
    logic all_done;

    spawn_out_top spawn_out_top_inst (
        .clk, .rstn, .in_valid, .in_data, .in_last, .in_ready,
        .out_valid, .out_data, .out_last, .out_ready, .spawn_ok, .spawn_full
    );

    always #2 clk = ~clk;

    // ####################
    // stimulus table with counts, ids, type, arch, out_ready hold-off and random stall flag.
    task automatic load_table();
        rows[0]  = '{4'd0, 4'd0, 4'd0, 64'h1000, 64'h0001, 32'hcafe0001, 2'd1, 16'd0, 1'b0};
        rows[1]  = '{4'd2, 4'd1, 4'd0, 64'h1001, 64'h1000, 32'h00000010, 2'd2, 16'd0, 1'b0};
        rows[2]  = '{4'd0, 4'd3, 4'd1, 64'h1002, 64'h1000, 32'h00000020, 2'd3, 16'd0, 1'b0};
        rows[3]  = '{4'd1, 4'd0, 4'd2, 64'h1003, 64'h1001, 32'hdead0030, 2'd1, 16'd0, 1'b0};
        rows[4]  = '{4'd5, 4'd5, 4'd1, 64'h1004, 64'h1002, 32'h00000040, 2'd2, 16'd0, 1'b0};
        rows[5]  = '{4'd0, 4'd0, 4'd0, 64'h1005, 64'h1004, 32'h00000050, 2'd0, 16'd0, 1'b0};
        // the hold-off here stalls the drain long enough for the queue to fill.
        rows[6]  = '{4'd3, 4'd2, 4'd0, 64'h2000, 64'h1005, 32'h00000060, 2'd1, 16'd600, 1'b0};
        rows[7]  = '{4'd15, 4'd15, 4'd4, 64'h2001, 64'h2000, 32'h00000070, 2'd3, 16'd0, 1'b0};
        rows[8]  = '{4'd15, 4'd15, 4'd4, 64'h2002, 64'h2000, 32'h00000080, 2'd2, 16'd0, 1'b0};
        rows[9]  = '{4'd15, 4'd15, 4'd4, 64'h2003, 64'h2001, 32'h00000090, 2'd1, 16'd0, 1'b0};
        rows[10] = '{4'd4, 4'd0, 4'd3, 64'h3000, 64'h2003, 32'h000000a0, 2'd2, 16'd0, 1'b1};
        rows[11] = '{4'd7, 4'd2, 4'd1, 64'h3001, 64'h3000, 32'h000000b0, 2'd3, 16'd0, 1'b1};
        rows[12] = '{4'd0, 4'd0, 4'd0, 64'h3002, 64'h3000, 32'h000000c0, 2'd0, 16'd0, 1'b1};
        rows[13] = '{4'd9, 4'd3, 4'd2, 64'h3003, 64'h3002, 32'h000000d0, 2'd1, 16'd0, 1'b1};
        rows[14] = '{4'd1, 4'd1, 4'd1, 64'h3004, 64'h3003, 32'h000000e0, 2'd2, 16'd0, 1'b1};
    endtask

    // input words and expected queue entries for every row.
    task automatic build_streams();
        int n_pay;
        logic [63:0] pay;
        for (int r = 0; r < NUM_ROWS; r++) begin
            n_pay = int'(rows[r].args) + int'(rows[r].deps) + 3 * int'(rows[r].cops);
            in_words.push_back({12'd0, rows[r].cops, rows[r].deps, rows[r].args, 6'd0,
                                rows[r].arch, rows[r].task_type});
            in_lasts.push_back(1'b0);
            in_words.push_back(rows[r].task_id);
            in_lasts.push_back(1'b0);
            in_words.push_back(rows[r].ptask_id);
            in_lasts.push_back(n_pay == 0);
            exp_words.push_back({8'h80, 32'd0, 4'd0, rows[r].cops, 4'd0, rows[r].deps,
                                 4'd0, rows[r].args});
            exp_lasts.push_back(1'b0);
            exp_words.push_back(rows[r].task_id);
            exp_lasts.push_back(1'b0);
            exp_words.push_back(rows[r].ptask_id);
            exp_lasts.push_back(1'b0);
            exp_words.push_back({30'd0, rows[r].arch, rows[r].task_type});
            exp_lasts.push_back(n_pay == 0);
            for (int p = 0; p < n_pay; p++) begin
                pay = {$urandom, $urandom};
                in_words.push_back(pay);
                in_lasts.push_back(p == n_pay - 1);
                exp_words.push_back(pay);
                exp_lasts.push_back(p == n_pay - 1);
            end
        end
        for (int i = 0; i < STALL_LEN; i++) begin
            stall_pat[i] = 1'($urandom_range(0, 1));
        end
    endtask

    task automatic check_word();
        logic [63:0] exp_d;
        logic exp_l;
        word_idx++;
        if (exp_words.size() == 0) begin
            $display("[ERROR] %0t: unexpected output word %h", $time, out_data);
            err_cnt++;
            entry_errs++;
        end else begin
            exp_d = exp_words.pop_front();
            exp_l = exp_lasts.pop_front();
            if (out_data !== exp_d) begin
                $display("[ERROR] %0t: entry %0d word %0d is %h, expected %h", $time,
                         cur_entry, word_idx, out_data, exp_d);
                err_cnt++;
                entry_errs++;
            end
            if (out_last !== exp_l) begin
                $display("[ERROR] %0t: entry %0d word %0d out_last %b, expected %b", $time,
                         cur_entry, word_idx, out_last, exp_l);
                err_cnt++;
                entry_errs++;
            end
        end
        if (out_last) begin
            $display("entry %0d: %0d words, %s", cur_entry, word_idx,
                     entry_errs == 0 ? "ok" : "mismatch");
            cur_entry++;
            word_idx = 0;
            entry_errs = 0;
            if (cur_entry < NUM_ROWS) begin
                hold_left = rows[cur_entry].hold;
            end else begin
                all_done = 1'b1;
            end
        end
    endtask

    // ####################
    // the input stream offers one word per cycle while any remain.
    always @(negedge clk) begin
        if (run_active) begin
            if (in_idx < in_words.size()) begin
                in_valid = 1'b1;
                in_data = in_words[in_idx];
                in_last = in_lasts[in_idx];
                if (in_ready) begin
                    in_idx++;
                end
            end else begin
                in_valid = 1'b0;
                in_last = 1'b0;
            end
        end
    end

    // output side drives out_ready, counts status pulses and checks words.
    always @(negedge clk) begin
        if (run_active && !all_done) begin
            if (spawn_ok) begin
                ok_cnt++;
            end
            if (spawn_full) begin
                full_cnt++;
                if (in_ready) begin
                    $display("[ERROR] %0t: in_ready high during a reject", $time);
                    err_cnt++;
                end
            end
            if (out_valid && hold_left > 0) begin
                out_ready = 1'b0;
                hold_left--;
            end else if (rows[cur_entry].rnd_stall) begin
                out_ready = stall_pat[stall_ptr];
                stall_ptr = (stall_ptr + 1) % STALL_LEN;
            end else begin
                out_ready = 1'b1;
            end
            if (out_valid && out_ready) begin
                check_word();
            end
        end
    end

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        in_last = 1'b0;
        out_ready = 1'b0;
        run_active = 1'b0;
        all_done = 1'b0;
        in_idx = 0;
        cur_entry = 0;
        word_idx = 0;
        entry_errs = 0;
        stall_ptr = 0;
        err_cnt = 0;
        ok_cnt = 0;
        full_cnt = 0;
        cycles = 0;
        void'($urandom(32'h2bf287bb));
        load_table();
        build_streams();
        limit = exp_words.size() * 40;
        hold_left = rows[0].hold;

        repeat (8) @(posedge clk);
        @(negedge clk);
        if (in_ready || out_valid || spawn_ok || spawn_full) begin
            $display("[ERROR] %0t: not idle in reset: in_ready %b out_valid %b ok %b full %b",
                     $time, in_ready, out_valid, spawn_ok, spawn_full);
            err_cnt++;
        end
        rstn <= 1'b1;
        run_active <= 1'b1;

        while (!all_done && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end

        if (!all_done) begin
            $display("timeout: %0d of %0d entries came out within %0d cycles",
                     cur_entry, NUM_ROWS, limit);
            err_cnt++;
        end
        if (ok_cnt != NUM_ROWS) begin
            $display("[ERROR] %0t: %0d spawn_ok pulses, expected %0d", $time, ok_cnt, NUM_ROWS);
            err_cnt++;
        end
        if (full_cnt == 0) begin
            $display("[ERROR] %0t: no spawn_full pulse while the output was held", $time);
            err_cnt++;
        end
        $display("summary: %0d entries, %0d spawn_ok, %0d spawn_full, %0d errors",
                 cur_entry, ok_cnt, full_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hw/spawn_queue_pkg.sv
hw/spawn_cmd_pkg.sv
hw/spawn_cmd_parser.sv
hw/spawn_queue_writer.sv
hw/spawn_queue_ram.sv
hw/spawn_queue_drain.sv
hw/spawn_out_top.sv
verification/spawn_out_tb.sv

// ==== Bender.yml ====
package:
  name: spawn_out

sources:
  - hw/spawn_queue_pkg.sv
  - hw/spawn_cmd_pkg.sv
  - hw/spawn_cmd_parser.sv
  - hw/spawn_queue_writer.sv
  - hw/spawn_queue_ram.sv
  - hw/spawn_queue_drain.sv
  - hw/spawn_out_top.sv
  - target: test
    files:
      - verification/spawn_out_tb.sv
